// File: project.f
hdl/calc_pkg.sv
hdl/calc_issue.sv
hdl/calc_pipe_int.sv
hdl/calc_pipe_mul.sv
hdl/calc_comp_pipe.sv
hdl/calc_exc_pipe.sv
hdl/calc_top.sv
dv/calc_assertions.sv
dv/calc_tb.sv

// File: Bender.yml
package:
  name: calc

sources:
  - files:
      - hdl/calc_pkg.sv
      - hdl/calc_issue.sv
      - hdl/calc_pipe_int.sv
      - hdl/calc_pipe_mul.sv
      - hdl/calc_comp_pipe.sv
      - hdl/calc_exc_pipe.sv
      - hdl/calc_top.sv
  - target: simulation
    files:
      - dv/calc_assertions.sv
      - dv/calc_tb.sv

// File: dv/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;

  typedef struct packed
  {
    int                                    edge_no;
    logic [calc_pkg::reg_addr_width_c-1:0] rd_addr;
    logic [calc_pkg::data_width_c-1:0]     rd_data;
  } wb_exp_s;

  typedef struct packed
  {
    int   edge_no;
    logic illegal;
  } commit_exp_s;

  logic                     clk;
  logic                     rst_n;
  calc_pkg::calc_dispatch_s dispatch_pkt;
  calc_pkg::calc_commit_s   commit_pkt;
  calc_pkg::calc_wb_s       iwb_pkt;

  // Program-order values for expected results, and values as they retire
  logic [calc_pkg::data_width_c-1:0] ref_regs [32];
  logic [calc_pkg::data_width_c-1:0] arch_regs [32];
  wb_exp_s                           wb_q[$];
  commit_exp_s                       commit_q[$];
  int                                edge_cnt = 0;
  int                                illegal_edge;
  int                                seed;

  calc_top uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .dispatch_pkt_i (dispatch_pkt),
    .commit_pkt_o   (commit_pkt),
    .iwb_pkt_o      (iwb_pkt)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
    edge_cnt <= edge_cnt + 1;

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  function automatic logic [31:0] expected_result(input calc_pkg::calc_op_e op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [31:0] res;
    case (op)
      calc_pkg::op_add: res = a + b;
      calc_pkg::op_sub: res = a - b;
      calc_pkg::op_and: res = a & b;
      calc_pkg::op_or:  res = a | b;
      calc_pkg::op_xor: res = a ^ b;
      calc_pkg::op_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_pkg::op_mul: res = a * b;
      default:          res = '0;
    endcase
    return res;
  endfunction

  function automatic logic [4:0] pick_reg(input int base, input int span);
    logic [31:0] r;
    r = $random(seed);
    return 5'(base + (r % span));
  endfunction

  function automatic calc_pkg::calc_op_e pick_alu_op();
    logic [31:0] r;
    r = $random(seed);
    return calc_pkg::calc_op_e'(3'(r % 6));
  endfunction

  task automatic send_op(input calc_pkg::calc_op_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    calc_pkg::calc_dispatch_s pkt;
    wb_exp_s                  we;
    commit_exp_s              ce;
    int                       sample_edge;
    @(posedge clk);
    sample_edge    = edge_cnt + 2;
    pkt            = '0;
    pkt.v          = 1'b1;
    pkt.op         = op;
    pkt.rs1_addr   = rs1;
    pkt.rs2_addr   = rs2;
    pkt.rd_addr    = rd;
    pkt.rs1_r_v    = 1'b1;
    pkt.rs2_r_v    = 1'b1;
    pkt.rd_w_v     = 1'b1;
    pkt.rs1        = arch_regs[rs1];
    pkt.rs2        = arch_regs[rs2];
    dispatch_pkt  <= pkt;
    ce.edge_no     = sample_edge + calc_pkg::commit_stage_c;
    ce.illegal     = (op == calc_pkg::op_rsvd);
    we.edge_no     = sample_edge + calc_pkg::wb_stage_c;
    we.rd_addr     = rd;
    we.rd_data     = expected_result(op, ref_regs[rs1], ref_regs[rs2]);
    // An illegal op takes out whatever is sampled on the three edges after it
    if (sample_edge - illegal_edge > 3)
    begin
      commit_q.push_back(ce);
      if (ce.illegal)
        illegal_edge = sample_edge;
      else
      begin
        ref_regs[rd] = we.rd_data;
        wb_q.push_back(we);
      end
    end
  endtask

  task automatic drain(input int max_cycles);
    int waited;
    @(posedge clk);
    dispatch_pkt <= '0;
    waited = 0;
    while ((wb_q.size() != 0 || commit_q.size() != 0) && waited < max_cycles)
    begin
      @(negedge clk);
      waited++;
    end
    if (wb_q.size() != 0 || commit_q.size() != 0)
    begin
      $display("timeout after %0d cycles with %0d writebacks and %0d commits missing",
               waited, wb_q.size(), commit_q.size());
      abort_run();
    end
  endtask

  always @(negedge clk)
  begin : monitor
    commit_exp_s ce;
    wb_exp_s     we;
    if (rst_n && commit_pkt.v)
    begin
      if (commit_q.size() == 0)
      begin
        $display("commit seen at edge %0d with no instruction expected", edge_cnt);
        abort_run();
      end
      else
      begin
        ce = commit_q.pop_front();
        check_value("commit_pkt_o.v edge", edge_cnt, ce.edge_no);
        check_value("commit_pkt_o.illegal", commit_pkt.illegal, ce.illegal);
        check_value("commit_pkt_o.flush", commit_pkt.flush, ce.illegal);
      end
    end
    if (rst_n && iwb_pkt.rd_w_v)
    begin
      if (wb_q.size() == 0)
      begin
        $display("writeback to r%0d at edge %0d with none expected", iwb_pkt.rd_addr,
                 edge_cnt);
        abort_run();
      end
      else
      begin
        we = wb_q.pop_front();
        check_value("iwb_pkt_o.rd_w_v edge", edge_cnt, we.edge_no);
        check_value("iwb_pkt_o.rd_addr", iwb_pkt.rd_addr, we.rd_addr);
        check_value("iwb_pkt_o.rd_data", iwb_pkt.rd_data, we.rd_data);
        arch_regs[we.rd_addr] = we.rd_data;
      end
    end
  end

  always @(uut.u_assertions.fail_count)
  begin
    if (uut.u_assertions.fail_count != 0)
    begin
      $display("a concurrent assertion on calc_top fired");
      abort_run();
    end
  end

  task automatic check_quiet_after_reset();
    repeat (8)
    begin
      @(negedge clk);
      check_value("commit_pkt_o.v", commit_pkt.v, 1'b0);
      check_value("iwb_pkt_o.rd_w_v", iwb_pkt.rd_w_v, 1'b0);
    end
  endtask

  task automatic run_alu_independent();
    logic [4:0] rd;
    logic [4:0] a;
    logic [4:0] b;
    // Sources from the low half, results to the high half
    for (int n = 0; n < 30; n++)
    begin
      rd = pick_reg(16, 16);
      a  = pick_reg(0, 16);
      b  = pick_reg(0, 16);
      send_op(calc_pkg::calc_op_e'(3'(n % 6)), rd, a, b);
    end
    drain(40);
  endtask

  task automatic run_forwarding();
    logic [4:0] rd;
    logic [4:0] a;
    logic [4:0] b;
    send_op(calc_pkg::op_add, 5, 5, 1);
    send_op(calc_pkg::op_xor, 5, 5, 2);
    send_op(calc_pkg::op_sub, 5, 5, 3);
    send_op(calc_pkg::op_or, 5, 5, 4);
    // All four stages now hold r5
    send_op(calc_pkg::op_and, 6, 7, 5);
    send_op(calc_pkg::op_slt, 7, 6, 5);
    send_op(calc_pkg::op_add, 8, 7, 7);
    for (int n = 0; n < 32; n++)
    begin
      rd = pick_reg(0, 4);
      a  = pick_reg(0, 4);
      b  = pick_reg(0, 4);
      send_op(pick_alu_op(), rd, a, b);
    end
    drain(40);
  endtask

  task automatic run_mul();
    logic [4:0] a;
    logic [4:0] b;
    for (int n = 0; n < 6; n++)
    begin
      a = pick_reg(8, 4);
      b = pick_reg(8, 4);
      send_op(calc_pkg::op_mul, 5'(20 + n), a, b);
    end
    send_op(calc_pkg::op_mul, 12, 8, 9);
    send_op(calc_pkg::op_or, 16, 10, 11);
    send_op(calc_pkg::op_and, 17, 10, 11);
    send_op(calc_pkg::op_add, 18, 12, 16);
    send_op(calc_pkg::op_mul, 19, 18, 12);
    drain(40);
  endtask

  task automatic run_illegal();
    send_op(calc_pkg::op_add, 1, 2, 3);
    send_op(calc_pkg::op_rsvd, 2, 3, 4);
    send_op(calc_pkg::op_add, 2, 3, 4);
    send_op(calc_pkg::op_sub, 5, 2, 1);
    send_op(calc_pkg::op_xor, 6, 5, 2);
    send_op(calc_pkg::op_add, 7, 2, 5);
    send_op(calc_pkg::op_sub, 2, 7, 1);
    send_op(calc_pkg::op_slt, 8, 2, 7);
    drain(40);
  endtask

  initial
  begin
    seed         = 34293;
    illegal_edge = -100;
    rst_n        = 1'b0;
    dispatch_pkt = '0;
    for (int i = 0; i < 32; i++)
    begin
      arch_regs[i] = $random(seed);
      ref_regs[i]  = arch_regs[i];
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    check_quiet_after_reset();
    run_alu_independent();
    run_forwarding();
    run_mul();
    run_illegal();
    repeat (8) @(negedge clk);
    if (uut.u_assertions.fail_count != 0)
    begin
      $display("concurrent assertions on calc_top reported failures");
      abort_run();
    end
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: dv/calc_assertions.sv
`timescale 1ns/1ps

module calc_assertions (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input calc_pkg::calc_commit_s commit_pkt_i,
  input calc_pkg::calc_wb_s     iwb_pkt_i
);

  int unsigned fail_count = 0;

  // A flush commits the faulting instruction and none of the three behind it
  flush_kills_younger_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    commit_pkt_i.flush |-> commit_pkt_i.v ##1 !commit_pkt_i.v ##1 !commit_pkt_i.v
                           ##1 !commit_pkt_i.v
  )
  else
  begin
    $error("commit flush without commit valid, or younger work committed after it");
    fail_count++;
  end

  // The flushed instruction reaches the writeback slot one cycle later
  flushed_no_wb_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    commit_pkt_i.flush |=> !iwb_pkt_i.rd_w_v
  )
  else
  begin
    $error("writeback from a flushed instruction");
    fail_count++;
  end

  reset_no_wb_a: assert property (
    @(posedge clk_i)
    !rst_n_i |-> !iwb_pkt_i.rd_w_v
  )
  else
  begin
    $error("writeback valid while in reset");
    fail_count++;
  end

endmodule

bind calc_top calc_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .commit_pkt_i (commit_pkt_o),
  .iwb_pkt_i    (iwb_pkt_o)
);

// File: hdl/calc_top.sv
`timescale 1ns/1ps

module calc_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  calc_pkg::calc_dispatch_s dispatch_pkt_i,
  output calc_pkg::calc_commit_s   commit_pkt_o,
  output calc_pkg::calc_wb_s       iwb_pkt_o
);

  calc_pkg::calc_dispatch_s                                       reservation;
  calc_pkg::calc_dispatch_s                                       reservation_n;
  calc_pkg::calc_wb_s [calc_pkg::comp_stages_c-1:0]               comp_match;
  logic [calc_pkg::comp_stages_c-1:0][calc_pkg::data_width_c-1:0] fwd_data;
  logic [calc_pkg::comp_stages_c-1:0]                             stage_v;
  logic [calc_pkg::data_width_c-1:0]                              int_data;
  logic [calc_pkg::data_width_c-1:0]                              mul_data;
  logic                                                           mul_v;
  logic                                                           int_illegal;
  logic                                                           flush;

  calc_issue u_issue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .dispatch_pkt_i  (dispatch_pkt_i),
    .flush_i         (flush),
    .comp_match_i    (comp_match),
    .fwd_data_i      (fwd_data),
    .reservation_o   (reservation),
    .reservation_n_o (reservation_n)
  );

  calc_pipe_int u_pipe_int (
    .reservation_i (reservation),
    .data_o        (int_data),
    .illegal_o     (int_illegal)
  );

  calc_pipe_mul u_pipe_mul (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reservation_i (reservation),
    .data_o        (mul_data),
    .v_o           (mul_v)
  );

  calc_comp_pipe u_comp_pipe (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reservation_n_i (reservation_n),
    .int_data_i      (int_data),
    .mul_data_i      (mul_data),
    .mul_v_i         (mul_v),
    .stage_v_i       (stage_v),
    .comp_match_o    (comp_match),
    .fwd_data_o      (fwd_data),
    .iwb_pkt_o       (iwb_pkt_o)
  );

  calc_exc_pipe u_exc_pipe (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reservation_n_i (reservation_n),
    .illegal_i       (int_illegal),
    .stage_v_o       (stage_v),
    .flush_o         (flush),
    .commit_pkt_o    (commit_pkt_o)
  );

endmodule

// File: hdl/calc_exc_pipe.sv
`timescale 1ns/1ps

module calc_exc_pipe (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  calc_pkg::calc_dispatch_s            reservation_n_i,
  input  logic                                illegal_i,
  output logic [calc_pkg::comp_stages_c-1:0]  stage_v_o,
  output logic                                flush_o,
  output calc_pkg::calc_commit_s              commit_pkt_o
);

  // Flags are only needed up to the commit stage
  logic [calc_pkg::comp_stages_c-1:0]  v_n;
  logic [calc_pkg::commit_stage_c:1]   illegal_n;
  logic [calc_pkg::commit_stage_c:0]   v_r;
  logic [calc_pkg::commit_stage_c:1]   illegal_r;

  always_comb
  begin
    v_n[0] = reservation_n_i.v;
    for (int i = 1; i < calc_pkg::comp_stages_c; i++)
      v_n[i] = v_r[i-1];

    // The ALU flags an illegal code on the way into stage 1
    illegal_n[1] = illegal_i;
    for (int i = 2; i <= calc_pkg::commit_stage_c; i++)
      illegal_n[i] = illegal_r[i-1];

    // Younger work dies, and the faulting instruction never reaches writeback
    for (int i = 0; i < calc_pkg::comp_stages_c; i++)
      v_n[i] &= ~flush_o;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      v_r       <= '0;
      illegal_r <= '0;
    end
    else
    begin
      v_r       <= v_n[calc_pkg::commit_stage_c:0];
      illegal_r <= illegal_n;
    end
  end

  assign commit_pkt_o.v       = v_r[calc_pkg::commit_stage_c];
  assign commit_pkt_o.illegal = v_r[calc_pkg::commit_stage_c] &
                                illegal_r[calc_pkg::commit_stage_c];
  assign commit_pkt_o.flush   = commit_pkt_o.illegal;

  assign flush_o   = commit_pkt_o.flush;
  assign stage_v_o = v_n;

endmodule

// File: hdl/calc_comp_pipe.sv
`timescale 1ns/1ps

module calc_comp_pipe (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  calc_pkg::calc_dispatch_s                                      reservation_n_i,
  input  logic [calc_pkg::data_width_c-1:0]                             int_data_i,
  input  logic [calc_pkg::data_width_c-1:0]                             mul_data_i,
  input  logic                                                          mul_v_i,
  input  logic [calc_pkg::comp_stages_c-1:0]                            stage_v_i,
  output calc_pkg::calc_wb_s [calc_pkg::comp_stages_c-1:0]              comp_match_o,
  output logic [calc_pkg::comp_stages_c-1:0][calc_pkg::data_width_c-1:0] fwd_data_o,
  output calc_pkg::calc_wb_s                                            iwb_pkt_o
);

  // One extra next-state entry holds what leaves the last stage
  calc_pkg::calc_wb_s [calc_pkg::comp_stages_c:0]   comp_stage_n;
  calc_pkg::calc_wb_s [calc_pkg::comp_stages_c-1:0] comp_stage_r;

  always_comb
  begin
    comp_stage_n[0].rd_w_v  = reservation_n_i.rd_w_v;
    comp_stage_n[0].rd_addr = reservation_n_i.rd_addr;
    comp_stage_n[0].rd_data = '0;
    for (int i = 1; i <= calc_pkg::comp_stages_c; i++)
      comp_stage_n[i] = comp_stage_r[i-1];

    // Latencies are fixed, so only one pipe finishes per slot
    comp_stage_n[1].rd_data |= int_data_i;
    if (mul_v_i)
      comp_stage_n[calc_pkg::mul_stage_c].rd_data |= mul_data_i;

    // Flushed and illegal instructions lose their write
    for (int i = 0; i < calc_pkg::comp_stages_c; i++)
      comp_stage_n[i].rd_w_v &= stage_v_i[i];
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      comp_stage_r <= '0;
    else
      comp_stage_r <= comp_stage_n[calc_pkg::comp_stages_c-1:0];
  end

  always_comb
  begin
    for (int i = 0; i < calc_pkg::comp_stages_c; i++)
      fwd_data_o[i] = comp_stage_n[i+1].rd_data;
  end

  assign comp_match_o = comp_stage_r;
  assign iwb_pkt_o    = comp_stage_r[calc_pkg::wb_stage_c];

endmodule

// File: hdl/calc_pipe_mul.sv
`timescale 1ns/1ps

module calc_pipe_mul (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  calc_pkg::calc_dispatch_s          reservation_i,
  output logic [calc_pkg::data_width_c-1:0] data_o,
  output logic                              v_o
);

  logic [calc_pkg::mul_half_width_c-1:0] a_lo, a_hi, b_lo, b_hi;
  logic [calc_pkg::data_width_c-1:0]     p_ll, p_cross;
  logic [calc_pkg::data_width_c-1:0]     p_ll_r;
  logic [calc_pkg::mul_half_width_c-1:0] p_cross_r;
  logic [calc_pkg::data_width_c-1:0]     prod_r;
  logic [1:0]                            v_r;

  assign {a_hi, a_lo} = reservation_i.rs1;
  assign {b_hi, b_lo} = reservation_i.rs2;

  // Only the low word is kept, so the high-high product never contributes
  assign p_ll    = a_lo * b_lo;
  assign p_cross = a_lo * b_hi + a_hi * b_lo;

  // Reservation register is the first of three stages
  always_ff @(posedge clk_i)
  begin
    p_ll_r    <= p_ll;
    p_cross_r <= p_cross[calc_pkg::mul_half_width_c-1:0];
    prod_r    <= p_ll_r + {p_cross_r, {calc_pkg::mul_half_width_c{1'b0}}};
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      v_r <= '0;
    else
      v_r <= {v_r[0], reservation_i.v && (reservation_i.op == calc_pkg::op_mul)};
  end

  assign data_o = prod_r;
  assign v_o    = v_r[1];

endmodule

// File: hdl/calc_pipe_int.sv
`timescale 1ns/1ps

module calc_pipe_int (
  input  calc_pkg::calc_dispatch_s          reservation_i,
  output logic [calc_pkg::data_width_c-1:0] data_o,
  output logic                              illegal_o
);

  logic [calc_pkg::data_width_c-1:0] rs1;
  logic [calc_pkg::data_width_c-1:0] rs2;
  logic                              lt;

  assign rs1 = reservation_i.rs1;
  assign rs2 = reservation_i.rs2;
  assign lt  = $signed(rs1) < $signed(rs2);

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::op_add:
        data_o = rs1 + rs2;
      calc_pkg::op_sub:
        data_o = rs1 - rs2;
      calc_pkg::op_and:
        data_o = rs1 & rs2;
      calc_pkg::op_or:
        data_o = rs1 | rs2;
      calc_pkg::op_xor:
        data_o = rs1 ^ rs2;
      calc_pkg::op_slt:
        data_o = {{(calc_pkg::data_width_c-1){1'b0}}, lt};
      // mul is merged later from its own pipe
      default:
        data_o = '0;
    endcase
  end

  assign illegal_o = reservation_i.v && (reservation_i.op == calc_pkg::op_rsvd);

endmodule

// File: hdl/calc_issue.sv
`timescale 1ns/1ps

module calc_issue (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  calc_pkg::calc_dispatch_s                                      dispatch_pkt_i,
  input  logic                                                          flush_i,
  input  calc_pkg::calc_wb_s [calc_pkg::comp_stages_c-1:0]              comp_match_i,
  input  logic [calc_pkg::comp_stages_c-1:0][calc_pkg::data_width_c-1:0] fwd_data_i,
  output calc_pkg::calc_dispatch_s                                      reservation_o,
  output calc_pkg::calc_dispatch_s                                      reservation_n_o
);

  calc_pkg::calc_dispatch_s reservation_n;
  calc_pkg::calc_dispatch_s reservation_r;

  // Youngest matching stage wins, so walk from oldest to youngest
  function automatic logic [calc_pkg::data_width_c-1:0] bypass_sel(
    input logic [calc_pkg::reg_addr_width_c-1:0] addr,
    input logic                                  r_v,
    input logic [calc_pkg::data_width_c-1:0]     dispatch_data
  );
    logic [calc_pkg::data_width_c-1:0] sel;
    sel = dispatch_data;
    for (int i = calc_pkg::comp_stages_c - 1; i >= 0; i--)
    begin
      if (r_v && comp_match_i[i].rd_w_v && (comp_match_i[i].rd_addr == addr))
        sel = fwd_data_i[i];
    end
    return sel;
  endfunction

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.v   = dispatch_pkt_i.v & ~flush_i;
    reservation_n.rs1 = bypass_sel(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1_r_v,
                                   dispatch_pkt_i.rs1);
    reservation_n.rs2 = bypass_sel(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2_r_v,
                                   dispatch_pkt_i.rs2);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      reservation_r <= '0;
    else
      reservation_r <= reservation_n;
  end

  assign reservation_o   = reservation_r;
  assign reservation_n_o = reservation_n;

endmodule

// File: hdl/calc_pkg.sv
package calc_pkg;

  localparam int data_width_c     = 32;
  localparam int reg_addr_width_c = 5;
  localparam int mul_half_width_c = data_width_c / 2;

  // Completion and exception pipe depth, and where things happen in it
  localparam int comp_stages_c  = 4;
  localparam int commit_stage_c = 2;
  localparam int wb_stage_c     = 3;
  localparam int mul_stage_c    = 3;

  typedef enum logic [2:0]
  {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_slt  = 3'd5,
    op_mul  = 3'd6,
    op_rsvd = 3'd7
  } calc_op_e;

  typedef struct packed
  {
    logic                        v;
    calc_op_e                    op;
    logic [reg_addr_width_c-1:0] rs1_addr;
    logic [reg_addr_width_c-1:0] rs2_addr;
    logic [reg_addr_width_c-1:0] rd_addr;
    logic                        rs1_r_v;
    logic                        rs2_r_v;
    logic                        rd_w_v;
    logic [data_width_c-1:0]     rs1;
    logic [data_width_c-1:0]     rs2;
  } calc_dispatch_s;

  typedef struct packed
  {
    logic                        rd_w_v;
    logic [reg_addr_width_c-1:0] rd_addr;
    logic [data_width_c-1:0]     rd_data;
  } calc_wb_s;

  // flush is v and illegal together
  typedef struct packed
  {
    logic v;
    logic illegal;
    logic flush;
  } calc_commit_s;

endpackage
